// ==== all.f ====
common/soc_pkg.sv
rtl/bus_decoder.sv
rtl/ctrl_regs.sv
work_ram/ram_arbiter.sv
work_ram/work_ram.sv
osd/osd_overlay.sv
rtl/soc_top.sv
verification/tb_soc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the soc testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tb_soc_top -f all.f -o sim_soc

./obj_dir/sim_soc | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0

// ==== verification/tb_soc_top.sv ====
//////////////////////////////////////////////////////////////////////
// soc top testbench
// register and work RAM accesses from a table, then two short frames
// of scan-out with the overlay on and off and bus reads alongside
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_soc_top;

  typedef struct packed {
    soc_pkg::bus_addr_t addr;
    soc_pkg::bus_data_t wdata;
    soc_pkg::bus_strb_t wstrb;
    soc_pkg::bus_data_t exp;
  } row_t;

  localparam int n_rows        = 20;
  localparam int n_scan        = 200;
  localparam int access_limit  = 16;
  localparam int access_cycles = access_limit + 4;
  localparam int line_cycles   = 300;
  localparam int frame_lines   = 70;
  localparam int frame_cycles  = 4 + frame_lines * line_cycles;
  localparam int limit_cycles  = (soc_pkg::ram_words + n_rows + 1) * access_cycles +
                                 2 * frame_cycles + 2000;

  logic                   clk;
  logic                   rst;
  soc_pkg::cpu_req_t      i_cpu;
  logic                   o_cpu_ready;
  soc_pkg::bus_data_t     o_cpu_rdata;
  soc_pkg::video_beat_t   i_video;
  soc_pkg::rgb_t          i_emu_rgb;
  soc_pkg::video_beat_t   o_video;
  soc_pkg::rgb_t          o_rgb;
  soc_pkg::emu_ctrl_t     o_emu_ctrl;
  soc_pkg::key_mask_t     o_keyboard_mask;

  integer seed = 32'h0439_889c;
  int     n_checks = 0;
  int     n_errors = 0;
  row_t   rows [n_rows];

  // byte model of work RAM and the overlay state
  logic [7:0]           ram_bytes [4 * soc_pkg::ram_words];
  logic                 m_en = 1'b0;
  int                   m_x = 0;
  int                   m_y = 0;
  logic [7:0]           m_shift = '0;
  logic                 m_load = 1'b0;
  logic [7:0]           m_byte = '0;
  logic                 have_prev = 1'b0;
  soc_pkg::rgb_t        prev_rgb;
  soc_pkg::video_beat_t prev_video;

  soc_top dut (
    .clk             (clk),
    .rst             (rst),
    .i_cpu           (i_cpu),
    .o_cpu_ready     (o_cpu_ready),
    .o_cpu_rdata     (o_cpu_rdata),
    .i_video         (i_video),
    .i_emu_rgb       (i_emu_rgb),
    .o_video         (o_video),
    .o_rgb           (o_rgb),
    .o_emu_ctrl      (o_emu_ctrl),
    .o_keyboard_mask (o_keyboard_mask)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(limit_cycles * 8);
    $display("run stopped by the watchdog after %0d cycles", limit_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic soc_pkg::bus_addr_t word_addr(input int w);
    return 32'h1000_0000 | (32'(w) << 2);
  endfunction

  // pattern spread over every address bit
  function automatic soc_pkg::bus_data_t fill_word(input int w);
    logic [31:0] wv;
    wv = 32'(w);
    return (wv * 32'h9e37_79b9) ^ {wv[15:0], ~wv[15:0]};
  endfunction

  function automatic soc_pkg::bus_data_t model_word(input int w);
    return {ram_bytes[w * 4 + 3], ram_bytes[w * 4 + 2],
            ram_bytes[w * 4 + 1], ram_bytes[w * 4]};
  endfunction

  task automatic model_write(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_data_t wdata,
                             input soc_pkg::bus_strb_t wstrb);
    int w;
    w = int'(addr[11:2]);
    if (addr[31:28] == soc_pkg::region_ram) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (wstrb[lane]) begin
          ram_bytes[w * 4 + lane] = wdata[8 * lane +: 8];
        end
      end
    end else if (addr == soc_pkg::reg_osd_ctrl && wstrb == 4'hf) begin
      m_en = wdata[0];
    end
  endtask

  // one valid/ready transaction that drops valid the cycle after ready
  task automatic cpu_access(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_data_t wdata,
                            input soc_pkg::bus_strb_t wstrb, output soc_pkg::bus_data_t rdata);
    int   waited;
    logic got_ready;
    rdata = '0;
    waited = 0;
    got_ready = 1'b0;
    @(posedge clk);
    i_cpu <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    while (!got_ready && waited < access_limit) begin
      @(negedge clk);
      if (o_cpu_ready) begin
        got_ready = 1'b1;
        rdata = o_cpu_rdata;
      end
      waited++;
    end
    if (!got_ready) begin
      n_errors++;
      $display("no ready from the bus port within %0d cycles for address %h",
               access_limit, addr);
    end
    @(posedge clk);
    i_cpu <= '0;
    @(negedge clk);
    if (o_cpu_ready) begin
      n_errors++;
      $display("a second ready came for the access to address %h", addr);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // overlay reference stepped once per beat

  task automatic model_step(input soc_pkg::video_beat_t b, input soc_pkg::rgb_t emu);
    logic in_win;
    logic fetch;
    in_win = m_en && b.de && (m_y < soc_pkg::osd_height) && (m_x < soc_pkg::osd_width);
    fetch = in_win && (m_x % 8 == 0);
    if (!b.de) begin
      prev_rgb = '0;
    end else if (in_win) begin
      prev_rgb = m_shift[7] ? soc_pkg::osd_fg : soc_pkg::osd_bg;
    end else begin
      prev_rgb = emu;
    end
    prev_video = b;
    // fetched byte lands in the shifter one cycle after the fetch
    if (m_load) begin
      m_shift = m_byte;
    end else begin
      m_shift = {m_shift[6:0], 1'b0};
    end
    m_load = fetch;
    if (fetch) begin
      m_byte = ram_bytes[m_y * (soc_pkg::osd_width / 8) + m_x / 8];
    end
    if (b.vs) begin
      m_y = 0;
    end else if (b.hs) begin
      if (m_x != 0) begin
        m_y++;
      end
      m_x = 0;
    end else if (b.de) begin
      m_x++;
    end
  endtask

  task automatic video_beat(input logic de, input logic hs, input logic vs);
    logic [31:0]          rnd;
    soc_pkg::video_beat_t b;
    rnd = $random(seed);
    b.de = de;
    b.hs = hs;
    b.vs = vs;
    @(posedge clk);
    i_video <= b;
    i_emu_rgb <= rnd[23:0];
    @(negedge clk);
    // outputs now show the beat driven one cycle earlier
    if (have_prev) begin
      check_value("o_video", 64'(o_video), 64'(prev_video));
      check_value("o_rgb", 64'(o_rgb), 64'(prev_rgb));
    end
    model_step(b, rnd[23:0]);
    have_prev = 1'b1;
  endtask

  task automatic run_frame();
    repeat (4) video_beat(1'b0, 1'b0, 1'b1);
    for (int line = 0; line < frame_lines; line++) begin
      for (int c = 0; c < line_cycles; c++) begin
        video_beat(c < 272, c >= 280 && c < 288, 1'b0);
      end
    end
  endtask

  // RAM reads that collide with overlay fetches
  task automatic scan_reads(input int first);
    soc_pkg::bus_data_t rdata;
    int                 w;
    for (int k = 0; k < n_scan; k++) begin
      repeat (50 + k % 8) @(posedge clk);
      w = (first + k * 37) % soc_pkg::ram_words;
      cpu_access(word_addr(w), '0, '0, rdata);
      check_value("o_cpu_rdata", 64'(rdata), 64'(model_word(w)));
    end
  endtask

  task automatic load_table();
    rows[0]  = '{32'h3000_0004, 32'hdead_beef, 4'hf, 32'h0};
    rows[1]  = '{32'h3000_0008, 32'h0123_4567, 4'hf, 32'h0};
    rows[2]  = '{32'h3000_000c, 32'hffff_ff15, 4'hf, 32'h0};
    rows[3]  = '{32'h3000_0000, 32'h0000_0001, 4'hf, 32'h0};
    rows[4]  = '{32'h3000_0004, 32'h0, 4'h0, 32'hdead_beef};
    rows[5]  = '{32'h3000_0008, 32'h0, 4'h0, 32'h0123_4567};
    rows[6]  = '{32'h3000_000c, 32'h0, 4'h0, 32'h0000_0015};
    // partial strobe leaves the enable set
    rows[7]  = '{32'h3000_0000, 32'h0, 4'h3, 32'h0};
    rows[8]  = '{32'h3000_0000, 32'h0, 4'h0, 32'h0000_0001};
    rows[9]  = '{32'h3000_0010, 32'h0, 4'h0, 32'h0};
    rows[10] = '{32'h1000_0040, 32'h0000_00a1, 4'h1, 32'h0};
    rows[11] = '{32'h1000_0040, 32'h0000_b200, 4'h2, 32'h0};
    rows[12] = '{32'h1000_0040, 32'h00c3_0000, 4'h4, 32'h0};
    rows[13] = '{32'h1000_0040, 32'hd400_0000, 4'h8, 32'h0};
    rows[14] = '{32'h1000_0040, 32'h0, 4'h0, 32'hd4c3_b2a1};
    rows[15] = '{32'h1000_0084, 32'h1234_5678, 4'hf, 32'h0};
    rows[16] = '{32'h1000_0084, 32'h0000_9a00, 4'h2, 32'h0};
    rows[17] = '{32'h1000_0084, 32'h0, 4'h0, 32'h1234_9a78};
    rows[18] = '{32'h2000_0000, 32'h0, 4'h0, 32'h0};
    rows[19] = '{32'h5000_0000, 32'h0, 4'h0, 32'h0};
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    soc_pkg::bus_data_t rdata;
    rst = 1'b1;
    i_cpu = '0;
    i_video = '0;
    i_emu_rgb = '0;
    load_table();
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    for (int w = 0; w < soc_pkg::ram_words; w++) begin
      cpu_access(word_addr(w), fill_word(w), 4'hf, rdata);
      model_write(word_addr(w), fill_word(w), 4'hf);
    end

    for (int i = 0; i < n_rows; i++) begin
      cpu_access(rows[i].addr, rows[i].wdata, rows[i].wstrb, rdata);
      model_write(rows[i].addr, rows[i].wdata, rows[i].wstrb);
      if (rows[i].wstrb == 4'h0) begin
        check_value("o_cpu_rdata", 64'(rdata), 64'(rows[i].exp));
      end
    end
    check_value("o_emu_ctrl", 64'(o_emu_ctrl), 64'h15);
    check_value("o_keyboard_mask", o_keyboard_mask, 64'h0123_4567_dead_beef);

    // overlay on
    fork
      run_frame();
      scan_reads(3);
    join

    cpu_access(soc_pkg::reg_osd_ctrl, 32'h0, 4'hf, rdata);
    model_write(soc_pkg::reg_osd_ctrl, 32'h0, 4'hf);

    // overlay off
    fork
      run_frame();
      scan_reads(500);
    join

    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/soc_top.sv ====
//////////////////////////////////////////////////////////////////////
// soc top
// processor bus port, control registers, shared work RAM and the
// on-screen-display overlay on the incoming picture
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module soc_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire soc_pkg::cpu_req_t i_cpu,
  output logic                  o_cpu_ready,
  output soc_pkg::bus_data_t    o_cpu_rdata,
  input  wire soc_pkg::video_beat_t i_video,
  input  wire soc_pkg::rgb_t    i_emu_rgb,
  output soc_pkg::video_beat_t  o_video,
  output soc_pkg::rgb_t         o_rgb,
  output soc_pkg::emu_ctrl_t    o_emu_ctrl,
  output soc_pkg::key_mask_t    o_keyboard_mask
);

  logic               reg_wr;
  soc_pkg::bus_data_t reg_rdata;
  logic               osd_enable;

  // work RAM port sharing
  soc_pkg::ram_req_t  cpu_ram_req;
  soc_pkg::ram_req_t  osd_fetch;
  soc_pkg::ram_req_t  ram_req;
  logic               cpu_grant;
  soc_pkg::bus_data_t ram_rdata;

  bus_decoder u_bus_decoder (
    .clk         (clk),
    .rst         (rst),
    .i_cpu       (i_cpu),
    .o_cpu_ready (o_cpu_ready),
    .o_cpu_rdata (o_cpu_rdata),
    .o_reg_wr    (reg_wr),
    .i_reg_rdata (reg_rdata),
    .o_ram_req   (cpu_ram_req),
    .i_ram_grant (cpu_grant),
    .i_ram_rdata (ram_rdata)
  );

  ctrl_regs u_ctrl_regs (
    .clk             (clk),
    .rst             (rst),
    .i_wr            (reg_wr),
    .i_addr          (i_cpu.addr),
    .i_wdata         (i_cpu.wdata),
    .o_rdata         (reg_rdata),
    .o_osd_enable    (osd_enable),
    .o_emu_ctrl      (o_emu_ctrl),
    .o_keyboard_mask (o_keyboard_mask)
  );

  ram_arbiter u_ram_arbiter (
    .i_cpu_req   (cpu_ram_req),
    .o_cpu_grant (cpu_grant),
    .i_osd_req   (osd_fetch),
    .o_ram_req   (ram_req)
  );

  work_ram u_work_ram (
    .clk     (clk),
    .i_req   (ram_req),
    .o_rdata (ram_rdata)
  );

  osd_overlay u_osd_overlay (
    .clk         (clk),
    .rst         (rst),
    .i_video     (i_video),
    .i_emu_rgb   (i_emu_rgb),
    .i_enable    (osd_enable),
    .o_fetch     (osd_fetch),
    .i_ram_rdata (ram_rdata),
    .o_video     (o_video),
    .o_rgb       (o_rgb)
  );

endmodule

`default_nettype wire

// ==== osd/osd_overlay.sv ====
//////////////////////////////////////////////////////////////////////
// osd overlay
// beam counters, 256x64 window, bitmap fetch from work RAM and
// the registered output colour mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module osd_overlay (
  input  wire                       clk,
  input  wire                       rst,
  input  wire soc_pkg::video_beat_t i_video,
  input  wire soc_pkg::rgb_t        i_emu_rgb,
  input  wire                       i_enable,
  output soc_pkg::ram_req_t         o_fetch,
  input  wire soc_pkg::bus_data_t   i_ram_rdata,
  output soc_pkg::video_beat_t      o_video,
  output soc_pkg::rgb_t             o_rgb
);

  soc_pkg::pix_coord_t x_q;
  soc_pkg::pix_coord_t y_q;
  logic                in_window;
  logic                fetch_now;
  logic                fetch_q;
  logic [10:0]         byte_addr;
  logic [1:0]          lane_q;
  logic [7:0]          fetch_byte;
  logic [7:0]          shift_q;
  soc_pkg::rgb_t       rgb_d;

  //////////////////////////////////////////////////////////////////////
  // beam position

  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
      y_q <= '0;
    end else if (i_video.vs) begin
      y_q <= '0;
    end else if (i_video.hs) begin
      x_q <= '0;
      // only count lines that had visible pixels
      if (x_q != '0) begin
        y_q <= y_q + 1'b1;
      end
    end else if (i_video.de) begin
      x_q <= x_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bitmap fetch of 32 bytes per line

  assign in_window = i_enable && i_video.de &&
                     (y_q < soc_pkg::pix_coord_t'(soc_pkg::osd_height)) &&
                     (x_q < soc_pkg::pix_coord_t'(soc_pkg::osd_width));
  assign fetch_now = in_window && (x_q[2:0] == 3'd0);
  assign byte_addr = {y_q[5:0], x_q[7:3]};

  assign o_fetch.en    = fetch_now;
  assign o_fetch.addr  = soc_pkg::ram_addr_t'(byte_addr[10:2]);
  assign o_fetch.wdata = '0;
  assign o_fetch.wstrb = '0;

  always_ff @(posedge clk) begin
    if (fetch_now) begin
      lane_q <= byte_addr[1:0];
    end
  end

  assign fetch_byte = i_ram_rdata[{lane_q, 3'b000} +: 8];

  //////////////////////////////////////////////////////////////////////
  // pixel shifter and output

  always_comb begin
    if (!i_video.de) begin
      rgb_d = '0;
    end else if (in_window) begin
      rgb_d = shift_q[7] ? soc_pkg::osd_fg : soc_pkg::osd_bg;
    end else begin
      rgb_d = i_emu_rgb;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= 1'b0;
      shift_q <= '0;
      o_video <= '0;
      o_rgb   <= '0;
    end else begin
      fetch_q <= fetch_now;
      // msb is the leftmost pixel
      if (fetch_q) begin
        shift_q <= fetch_byte;
      end else begin
        shift_q <= {shift_q[6:0], 1'b0};
      end
      o_video <= i_video;
      o_rgb   <= rgb_d;
    end
  end

endmodule

`default_nettype wire

// ==== work_ram/work_ram.sv ====
//////////////////////////////////////////////////////////////////////
// work ram
// 1024 words in four byte lanes, per-lane writes, one-cycle read
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module work_ram (
  input  wire                    clk,
  input  wire soc_pkg::ram_req_t i_req,
  output soc_pkg::bus_data_t     o_rdata
);

  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    logic [7:0] mem [soc_pkg::ram_words];
    logic [7:0] rd_q;

    // read returns the old byte on a write cycle
    always_ff @(posedge clk) begin
      if (i_req.en) begin
        if (i_req.wstrb[lane]) begin
          mem[i_req.addr] <= i_req.wdata[8*lane +: 8];
        end
        rd_q <= mem[i_req.addr];
      end
    end

    assign o_rdata[8*lane +: 8] = rd_q;
  end

endmodule

`default_nettype wire

// ==== work_ram/ram_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// ram arbiter
// fixed priority for the single work RAM port with the overlay fetch first
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ram_arbiter (
  input  wire soc_pkg::ram_req_t i_cpu_req,
  output logic                   o_cpu_grant,
  input  wire soc_pkg::ram_req_t i_osd_req,
  output soc_pkg::ram_req_t      o_ram_req
);

  logic osd_wins;

  // a fetch must land in its own cycle, the processor can wait
  assign osd_wins = i_osd_req.en;

  assign o_cpu_grant = i_cpu_req.en && !osd_wins;

  always_comb begin
    if (osd_wins) begin
      o_ram_req = i_osd_req;
    end else begin
      o_ram_req = i_cpu_req;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ctrl_regs.sv ====
//////////////////////////////////////////////////////////////////////
// control registers
// display enable, emulator control and 64-bit keyboard mask
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ctrl_regs (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_wr,
  input  wire soc_pkg::bus_addr_t i_addr,
  input  wire soc_pkg::bus_data_t i_wdata,
  output soc_pkg::bus_data_t      o_rdata,
  output logic                    o_osd_enable,
  output soc_pkg::emu_ctrl_t      o_emu_ctrl,
  output soc_pkg::key_mask_t      o_keyboard_mask
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_osd_enable    <= 1'b0;
      o_emu_ctrl      <= '0;
      o_keyboard_mask <= '0;
    end else if (i_wr) begin
      case (i_addr)
        soc_pkg::reg_osd_ctrl:   o_osd_enable <= i_wdata[0];
        soc_pkg::reg_keymask_lo: o_keyboard_mask[31:0] <= i_wdata;
        soc_pkg::reg_keymask_hi: o_keyboard_mask[63:32] <= i_wdata;
        soc_pkg::reg_emu_ctrl:   o_emu_ctrl <= i_wdata[4:0];
        default: begin
        end
      endcase
    end
  end

  // zero-extended readback
  always_comb begin
    case (i_addr)
      soc_pkg::reg_osd_ctrl:   o_rdata = {31'd0, o_osd_enable};
      soc_pkg::reg_keymask_lo: o_rdata = o_keyboard_mask[31:0];
      soc_pkg::reg_keymask_hi: o_rdata = o_keyboard_mask[63:32];
      soc_pkg::reg_emu_ctrl:   o_rdata = {27'd0, o_emu_ctrl};
      default:                 o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/bus_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// bus decoder
// region decode, valid/ready handshake and response data select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
  input  wire                    clk,
  input  wire                    rst,
  input  wire soc_pkg::cpu_req_t i_cpu,
  output logic                   o_cpu_ready,
  output soc_pkg::bus_data_t     o_cpu_rdata,
  output logic                   o_reg_wr,
  input  wire soc_pkg::bus_data_t i_reg_rdata,
  output soc_pkg::ram_req_t      o_ram_req,
  input  wire                    i_ram_grant,
  input  wire soc_pkg::bus_data_t i_ram_rdata
);

  soc_pkg::bus_state_e state_q;
  soc_pkg::bus_state_e state_d;
  logic [3:0]          region;
  logic                is_ram;
  logic                is_regs;

  assign region  = i_cpu.addr[31:28];
  assign is_ram  = (region == soc_pkg::region_ram);
  assign is_regs = (region == soc_pkg::region_regs);

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_pkg::idle: begin
        // regs and holes answer next cycle, RAM waits for its grant
        if (i_cpu.valid) begin
          if (!is_ram || i_ram_grant) begin
            state_d = soc_pkg::respond;
          end else begin
            state_d = soc_pkg::wait_ram;
          end
        end
      end
      soc_pkg::wait_ram: begin
        if (i_ram_grant) begin
          state_d = soc_pkg::respond;
        end
      end
      default: begin
        state_d = soc_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= soc_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // register writes need the full strobe
  assign o_reg_wr = (state_q == soc_pkg::idle) && i_cpu.valid && is_regs &&
                    (i_cpu.wstrb == 4'b1111);

  // request held until granted, dropped while responding
  assign o_ram_req.en    = i_cpu.valid && is_ram && (state_q != soc_pkg::respond);
  assign o_ram_req.addr  = i_cpu.addr[11:2];
  assign o_ram_req.wdata = i_cpu.wdata;
  assign o_ram_req.wstrb = i_cpu.wstrb;

  assign o_cpu_ready = (state_q == soc_pkg::respond);

  always_comb begin
    o_cpu_rdata = '0;
    if (o_cpu_ready) begin
      if (is_ram) begin
        o_cpu_rdata = i_ram_rdata;
      end else if (is_regs) begin
        o_cpu_rdata = i_reg_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== common/soc_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// soc package
// address map, sizes, colours and shared types of the bus port,
// work RAM and on-screen display
//////////////////////////////////////////////////////////////////////

`default_nettype none

package soc_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  // all zero means read
  typedef logic [3:0]  bus_strb_t;
  typedef logic [9:0]  ram_addr_t;
  typedef logic [8:0]  pix_coord_t;
  typedef logic [23:0] rgb_t;
  typedef logic [63:0] key_mask_t;
  // run bit plus two joystick selects
  typedef logic [4:0]  emu_ctrl_t;

  //////////////////////////////////////////////////////////////////////
  // bundles

  typedef struct packed {
    logic      valid;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_strb_t wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
  } video_beat_t;

  // one cycle on the single RAM port
  typedef struct packed {
    logic      en;
    ram_addr_t addr;
    bus_data_t wdata;
    bus_strb_t wstrb;
  } ram_req_t;

  typedef enum logic [1:0] {
    idle,
    wait_ram,
    respond
  } bus_state_e;

  //////////////////////////////////////////////////////////////////////
  // address map

  // top address nibble
  localparam logic [3:0] region_ram  = 4'h1;
  localparam logic [3:0] region_regs = 4'h3;

  localparam bus_addr_t reg_osd_ctrl   = 32'h3000_0000;
  localparam bus_addr_t reg_keymask_lo = 32'h3000_0004;
  localparam bus_addr_t reg_keymask_hi = 32'h3000_0008;
  localparam bus_addr_t reg_emu_ctrl   = 32'h3000_000c;

  // osd window with one bit per pixel
  localparam int osd_width  = 256;
  localparam int osd_height = 64;

  localparam rgb_t osd_fg = 24'hff_ffff;
  localparam rgb_t osd_bg = 24'h30_4050;

  localparam int ram_words = 1024;

endpackage

`default_nettype wire
